//--- flist.f
+incdir+.
FpTypes.sv
FpOpTypes.sv
FpPipeReg.sv
FpClassifier.sv
FpSignUnit.sv
FpComparator.sv
Fp32Unit.sv
FpUnitTop.sv
FpUnitTop_assertions.sv
FpUnitTop_tb.sv

//--- Bender.yml
package:
  name: fp_unit

sources:
  - include_dirs:
      - .
    files:
      - FpTypes.sv
      - FpOpTypes.sv
      - FpPipeReg.sv
      - FpClassifier.sv
      - FpSignUnit.sv
      - FpComparator.sv
      - Fp32Unit.sv
      - FpUnitTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - FpUnitTop_assertions.sv
      - FpUnitTop_tb.sv

//--- FpUnitTop_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench of the registered FP execute unit. Drives xorshift
// requests on the falling edge, predicts each response with its own
// model of the F-extension rules and checks order and latency.
// Ends with one line of error counts.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "FpUnit_defines.svh"

module FpUnitTop_tb;

    import FpTypes::*;
    import FpOpTypes::*;

    localparam int NUM_REQUESTS   = 400;
    localparam int CLK_PERIOD     = 10;
    localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 2 + 100;

    logic        clk;
    logic        reset;
    logic        inValid;
    logic        outValid;
    FpRequest_t  req;
    FpResponse_t rsp;

    logic [31:0] rngState = 32'd53;
    FpResponse_t expQ[$];
    int          dueQ[$];
    string       nameQ[$];
    int          cycle = 0;
    int          issued = 0;
    int          valueErrors = 0;
    int          protocolErrors = 0;

    FpUnitTop dut (
        .clk(clk), .reset(reset), .inValid(inValid), .req(req),
        .outValid(outValid), .rsp(rsp)
    );

    bind FpUnitTop FpUnitTop_assertions assertions (
        .clk(clk), .reset(reset), .inValid(inValid), .outValid(outValid), .rsp(rsp)
    );

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // about a third special values
    function automatic word_t randOperand();
        word_t r;
        word_t sel;
        r   = nextRand();
        sel = nextRand();
        if (sel % 3 != 0) return r;
        case (sel[6:4])
            3'd0: return 32'h0000_0000;
            3'd1: return 32'h8000_0000;
            3'd2: return 32'h7F80_0000;
            3'd3: return 32'hFF80_0000;
            3'd4: return {r[31], 8'hFF, 1'b1, r[21:0]};
            3'd5: return {r[31], 8'hFF, 1'b0, r[21:1], 1'b1};
            default: return {r[31], 8'h00, r[22:1], 1'b1};
        endcase
    endfunction

    function automatic logic isNan(word_t v);
        return v[30:23] == 8'hFF && v[22:0] != 23'd0;
    endfunction

    // unsigned key in total order with -0 just below +0
    function automatic word_t orderKey(word_t v);
        return v[31] ? ~v : (v | 32'h8000_0000);
    endfunction

    function automatic word_t classWord(word_t v);
        int pos;
        if (v[30:23] == 8'hFF && v[22:0] == 23'd0) begin
            pos = v[31] ? `FP_CLASS_NEG_INF : `FP_CLASS_POS_INF;
        end else if (v[30:23] == 8'hFF) begin
            pos = v[22] ? `FP_CLASS_QUIET_NAN : `FP_CLASS_SIGNALING_NAN;
        end else if (v[30:0] == 31'd0) begin
            pos = v[31] ? `FP_CLASS_NEG_ZERO : `FP_CLASS_POS_ZERO;
        end else if (v[30:23] == 8'h00) begin
            pos = v[31] ? `FP_CLASS_NEG_SUBNORMAL : `FP_CLASS_POS_SUBNORMAL;
        end else begin
            pos = v[31] ? `FP_CLASS_NEG_NORMAL : `FP_CLASS_POS_NORMAL;
        end
        return 32'd1 << pos;
    endfunction

    function automatic FpResponse_t expected(FpRequest_t r);
        FpResponse_t e;
        word_t       a;
        word_t       b;
        word_t       ka;
        word_t       kb;
        logic        nan;
        logic        snan;
        logic        s;
        e    = '0;
        a    = r.fpSrc1;
        b    = r.fpSrc2;
        nan  = isNan(a) || isNan(b);
        snan = (isNan(a) && !a[22]) || (isNan(b) && !b[22]);
        // compares see both zeros as +0
        ka   = orderKey(a[30:0] == 31'd0 ? 32'h0 : a);
        kb   = orderKey(b[30:0] == 31'd0 ? 32'h0 : b);
        case (r.unit)
            FpUnitType_Move: begin
                e.intResult = a;
                e.fpResult  = r.intSrc;
            end
            FpUnitType_Classifier: e.intResult = classWord(a);
            FpUnitType_Sign: begin
                case (r.command.sign)
                    FpSignCommand_Sgnj:  s = b[31];
                    FpSignCommand_Sgnjn: s = ~b[31];
                    FpSignCommand_Sgnjx: s = a[31] ^ b[31];
                    default:             s = a[31];
                endcase
                e.fpResult = {s, a[30:0]};
            end
            FpUnitType_Comparator: begin
                e.writeFlags = 1'b1;
                e.flags.nv   = snan;
                case (r.command.cmp)
                    FpCmpCommand_Eq: e.intResult = {31'b0, !nan && ka == kb};
                    FpCmpCommand_Lt: begin
                        e.intResult = {31'b0, !nan && ka < kb};
                        e.flags.nv  = nan;
                    end
                    FpCmpCommand_Le: begin
                        e.intResult = {31'b0, !nan && ka <= kb};
                        e.flags.nv  = nan;
                    end
                    default: begin
                        if (isNan(a) && isNan(b)) e.fpResult = `FP_CANONICAL_NAN;
                        else if (isNan(a)) e.fpResult = b;
                        else if (isNan(b)) e.fpResult = a;
                        else if ((orderKey(a) < orderKey(b)) == (r.command.cmp == FpCmpCommand_Min))
                            e.fpResult = a;
                        else e.fpResult = b;
                    end
                endcase
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic string testName(FpRequest_t r);
        if (r.unit == FpUnitType_Sign) return r.command.sign.name();
        if (r.unit == FpUnitType_Comparator) return r.command.cmp.name();
        if (r.unit > FpUnitType_Comparator) return "unused_unit";
        return r.unit.name();
    endfunction

    task automatic checkWord(string name, string field, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            valueErrors++;
            $display("FAIL %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    task automatic checkOutput();
        FpResponse_t exp;
        string       name;
        int          due;
        if (outValid) begin
            assert (expQ.size() > 0) else begin
                protocolErrors++;
                $display("outValid high at cycle %0d with no request outstanding", cycle);
            end
            if (expQ.size() > 0) begin
                exp  = expQ.pop_front();
                name = nameQ.pop_front();
                due  = dueQ.pop_front();
                assert (due == cycle) else begin
                    protocolErrors++;
                    $display("%s response came at cycle %0d instead of %0d", name, cycle, due);
                end
                checkWord(name, "intResult", exp.intResult, rsp.intResult);
                checkWord(name, "fpResult", exp.fpResult, rsp.fpResult);
                checkWord(name, "flags", {26'b0, exp.writeFlags, exp.flags},
                          {26'b0, rsp.writeFlags, rsp.flags});
            end
        end else if (dueQ.size() > 0) begin
            assert (dueQ[0] > cycle) else begin
                protocolErrors++;
                $display("%s response missing at cycle %0d", nameQ[0], cycle);
                void'(expQ.pop_front());
                void'(dueQ.pop_front());
                void'(nameQ.pop_front());
            end
        end
    endtask

    task automatic driveNext();
        word_t r;
        r = nextRand();
        if (issued < NUM_REQUESTS && r[1:0] != 2'b00) begin
            req.unit         = FpUnitType'(r[4:2] % 3'd5);
            req.command.sign = FpSignCommand'(r[6:5] % 2'd3);
            req.command.cmp  = FpCmpCommand'(r[9:7] % 3'd5);
            req.intSrc       = nextRand();
            req.fpSrc1       = randOperand();
            // equal operands now and then
            req.fpSrc2       = (r[12:10] == 3'd0) ? req.fpSrc1 : randOperand();
            inValid          = 1'b1;
            expQ.push_back(expected(req));
            dueQ.push_back(cycle + 2);
            nameQ.push_back(testName(req));
            issued++;
        end else begin
            inValid = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        reset   = 1'b1;
        // a request held during reset must never come out
        inValid = 1'b1;
        req     = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        while (issued < NUM_REQUESTS || expQ.size() > 0) begin
            checkOutput();
            driveNext();
            @(negedge clk);
            cycle++;
        end
        checkOutput();
        $display("errors: %0d value, %0d protocol, %0d requests issued",
                 valueErrors, protocolErrors, issued);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- FpUnitTop_assertions.sv
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the registered FP execute unit, bound to
// its top level by the testbench. Covers outValid after reset, the
// two-cycle valid latency and the flags that may ever be raised.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module FpUnitTop_assertions (
    input logic                   clk,
    input logic                   reset,
    input logic                   inValid,
    input logic                   outValid,
    input FpOpTypes::FpResponse_t rsp
);

    // rising edges since reset dropped, stops at 2
    logic [1:0] sinceReset;

    always_ff @(posedge clk) begin
        if (reset) begin
            sinceReset <= 2'd0;
        end else if (sinceReset != 2'd2) begin
            sinceReset <= sinceReset + 2'd1;
        end
    end

    validAfterReset: assert property (@(posedge clk) reset |=> !outValid)
        else $error("outValid high in the cycle after reset");

    validLatency: assert property (@(posedge clk) disable iff (reset)
        sinceReset == 2'd2 |-> outValid == $past(inValid, 2))
        else $error("outValid does not follow inValid by two cycles");

    // only NV can come out of these operations
    flagsOnlyNv: assert property (@(posedge clk) disable iff (reset)
        outValid |-> !(rsp.flags.dz || rsp.flags.of || rsp.flags.uf || rsp.flags.nx))
        else $error("rsp.flags has a flag other than NV set");

endmodule

//--- FpUnitTop.sv
//////////////////////////////////////////////////////////////////////
// Registered wrapper of the execute unit. A request sampled with
// inValid high comes back on rsp with outValid two edges later.
// One request may enter per cycle and there is no back-pressure,
// so the consumer takes rsp in the cycle outValid is high.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module FpUnitTop (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inValid,
    input  FpOpTypes::FpRequest_t  req,
    output logic                   outValid,
    output FpOpTypes::FpResponse_t rsp
);

    import FpOpTypes::*;

    FpRequest_t  reqReg;
    logic        reqValid;
    FpResponse_t rspComb;

    // stage 1, operand register
    FpPipeReg #(
        .payload_t (FpRequest_t)
    ) reqStage (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .in       (req),
        .outValid (reqValid),
        .out      (reqReg)
    );

    Fp32Unit execUnit (
        .unit            (reqReg.unit),
        .command         (reqReg.command),
        .intSrc          (reqReg.intSrc),
        .fpSrc1          (reqReg.fpSrc1),
        .fpSrc2          (reqReg.fpSrc2),
        .intResult       (rspComb.intResult),
        .fpResult        (rspComb.fpResult),
        .writeFlags      (rspComb.writeFlags),
        .writeFlagsValue (rspComb.flags)
    );

    // stage 2, result register
    FpPipeReg #(
        .payload_t (FpResponse_t)
    ) rspStage (
        .clk      (clk),
        .reset    (reset),
        .inValid  (reqValid),
        .in       (rspComb),
        .outValid (outValid),
        .out      (rsp)
    );

endmodule

//--- Fp32Unit.sv
//////////////////////////////////////////////////////////////////////
// Combinational single-precision execute unit. Runs the classifier,
// sign and compare sub-units side by side and selects one result
// set by unit type, together with the flag-write control.
// Results of unselected paths are driven to zero.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module Fp32Unit (
    input  FpOpTypes::FpUnitType    unit,
    input  FpOpTypes::FpUnitCommand command,
    input  FpTypes::word_t          intSrc,
    input  FpTypes::word_t          fpSrc1,
    input  FpTypes::word_t          fpSrc2,
    output FpTypes::word_t          intResult,
    output FpTypes::word_t          fpResult,
    output logic                    writeFlags,
    output FpTypes::fflags_t        writeFlagsValue
);

    import FpTypes::*;
    import FpOpTypes::*;

    word_t classWord;
    FpClassifier classifier (
        .fpSrc     (fpSrc1),
        .classWord (classWord)
    );

    word_t fpResultSign;
    FpSignUnit signUnit (
        .command  (command.sign),
        .fpSrc1   (fpSrc1),
        .fpSrc2   (fpSrc2),
        .fpResult (fpResultSign)
    );

    word_t   intResultCmp;
    word_t   fpResultCmp;
    fflags_t flagsCmp;
    FpComparator comparator (
        .command   (command.cmp),
        .fpSrc1    (fpSrc1),
        .fpSrc2    (fpSrc2),
        .intResult (intResultCmp),
        .fpResult  (fpResultCmp),
        .flags     (flagsCmp)
    );

    always_comb begin
        intResult       = '0;
        fpResult        = '0;
        writeFlags      = 1'b0;
        writeFlagsValue = '0;
        case (unit)
            FpUnitType_Move: begin
                // FMV.X.W and FMV.W.X, raw bit copies
                intResult = fpSrc1;
                fpResult  = intSrc;
            end
            FpUnitType_Classifier: begin
                intResult = classWord;
            end
            FpUnitType_Sign: begin
                fpResult = fpResultSign;
            end
            FpUnitType_Comparator: begin
                intResult       = intResultCmp;
                fpResult        = fpResultCmp;
                writeFlags      = 1'b1;
                writeFlagsValue = flagsCmp;
            end
            default: begin
                // omitted units answer with zeros
                writeFlags = 1'b0;
            end
        endcase
    end

endmodule

//--- FpComparator.sv
//////////////////////////////////////////////////////////////////////
// Compare and min/max for FEQ.S, FLT.S, FLE.S, FMIN.S and FMAX.S.
// Compares write 0/1 to the integer result, min/max write the FP
// result. NV follows the RISC-V rules for quiet and signaling NaNs.
// Outputs a command does not use are zero. Purely combinational.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "FpUnit_defines.svh"

module FpComparator (
    input  FpOpTypes::FpCmpCommand command,
    input  FpTypes::word_t         fpSrc1,
    input  FpTypes::word_t         fpSrc2,
    output FpTypes::word_t         intResult,
    output FpTypes::word_t         fpResult,
    output FpTypes::fflags_t       flags
);

    import FpTypes::*;
    import FpOpTypes::*;

    fp32_t a;
    fp32_t b;
    logic [`FP_EXP_WIDTH+`FP_FRAC_WIDTH-1:0] magA;
    logic [`FP_EXP_WIDTH+`FP_FRAC_WIDTH-1:0] magB;

    logic aNan, bNan, aSnan, bSnan;
    logic anyNan, anySnan;
    logic bothZero;
    logic equal;
    logic lessSigned;
    logic lessOrdered;

    assign a    = fpSrc1;
    assign b    = fpSrc2;
    assign magA = {a.exponent, a.fraction};
    assign magB = {b.exponent, b.fraction};

    assign aNan  = (&a.exponent) && (|a.fraction);
    assign bNan  = (&b.exponent) && (|b.fraction);
    assign aSnan = aNan && !a.fraction[`FP_FRAC_WIDTH-1];
    assign bSnan = bNan && !b.fraction[`FP_FRAC_WIDTH-1];

    assign anyNan   = aNan || bNan;
    assign anySnan  = aSnan || bSnan;
    assign bothZero = (magA == '0) && (magB == '0);

    // -0 and +0 compare equal for FEQ
    assign equal = !anyNan && ((fpSrc1 == fpSrc2) || bothZero);

    // ordering with -0 below +0, as min/max want it
    assign lessSigned = (a.sign != b.sign) ? a.sign :
                        (a.sign ? (magA > magB) : (magA < magB));

    // FLT ordering, zeros of either sign are equal here
    assign lessOrdered = !anyNan && !bothZero && lessSigned;

    always_comb begin
        intResult = '0;
        fpResult  = '0;
        flags     = '0;
        case (command)
            FpCmpCommand_Eq: begin
                intResult = {31'b0, equal};
                flags.nv  = anySnan;
            end
            FpCmpCommand_Lt: begin
                intResult = {31'b0, lessOrdered};
                flags.nv  = anyNan;
            end
            FpCmpCommand_Le: begin
                intResult = {31'b0, lessOrdered || equal};
                flags.nv  = anyNan;
            end
            FpCmpCommand_Min, FpCmpCommand_Max: begin
                if (aNan && bNan) begin
                    fpResult = `FP_CANONICAL_NAN;
                end else if (aNan) begin
                    fpResult = fpSrc2;
                end else if (bNan) begin
                    fpResult = fpSrc1;
                end else if (command == FpCmpCommand_Min) begin
                    fpResult = lessSigned ? fpSrc1 : fpSrc2;
                end else begin
                    fpResult = lessSigned ? fpSrc2 : fpSrc1;
                end
                // quiet NaNs are silent for min/max
                flags.nv = anySnan;
            end
            default: begin
                intResult = '0;
            end
        endcase
    end

endmodule

//--- FpSignUnit.sv
//////////////////////////////////////////////////////////////////////
// Sign injection for FSGNJ.S, FSGNJN.S and FSGNJX.S. The magnitude
// always comes from the first source; only the sign bit changes.
// Purely combinational, never raises a flag.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module FpSignUnit (
    input  FpOpTypes::FpSignCommand command,
    input  FpTypes::word_t          fpSrc1,
    input  FpTypes::word_t          fpSrc2,
    output FpTypes::word_t          fpResult
);

    import FpTypes::*;
    import FpOpTypes::*;

    fp32_t src1;
    fp32_t src2;
    fp32_t result;

    assign src1 = fpSrc1;
    assign src2 = fpSrc2;

    always_comb begin
        result = src1;
        case (command)
            FpSignCommand_Sgnj:  result.sign = src2.sign;
            FpSignCommand_Sgnjn: result.sign = ~src2.sign;
            FpSignCommand_Sgnjx: result.sign = src1.sign ^ src2.sign;
            // unused encoding keeps src1 as it is
            default:             result.sign = src1.sign;
        endcase
    end

    assign fpResult = result;

endmodule

//--- FpClassifier.sv
//////////////////////////////////////////////////////////////////////
// FCLASS.S decoder. Sets exactly one of the ten class bits for the
// operand and leaves the upper bits of the word at zero.
// Purely combinational.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "FpUnit_defines.svh"

module FpClassifier (
    input  FpTypes::word_t fpSrc,
    output FpTypes::word_t classWord
);

    import FpTypes::*;

    fp32_t x;
    logic  expAllOnes;
    logic  expZero;
    logic  fracZero;
    logic  quietBit;

    assign x          = fpSrc;
    assign expAllOnes = &x.exponent;
    assign expZero    = ~|x.exponent;
    assign fracZero   = ~|x.fraction;
    // top fraction bit tells quiet from signaling
    assign quietBit   = x.fraction[`FP_FRAC_WIDTH-1];

    always_comb begin
        classWord = '0;
        if (expAllOnes) begin
            if (fracZero) begin
                if (x.sign) classWord[`FP_CLASS_NEG_INF] = 1'b1;
                else        classWord[`FP_CLASS_POS_INF] = 1'b1;
            end else begin
                // NaN class ignores the sign
                if (quietBit) classWord[`FP_CLASS_QUIET_NAN]     = 1'b1;
                else          classWord[`FP_CLASS_SIGNALING_NAN] = 1'b1;
            end
        end else if (expZero) begin
            if (fracZero) begin
                if (x.sign) classWord[`FP_CLASS_NEG_ZERO] = 1'b1;
                else        classWord[`FP_CLASS_POS_ZERO] = 1'b1;
            end else begin
                if (x.sign) classWord[`FP_CLASS_NEG_SUBNORMAL] = 1'b1;
                else        classWord[`FP_CLASS_POS_SUBNORMAL] = 1'b1;
            end
        end else begin
            if (x.sign) classWord[`FP_CLASS_NEG_NORMAL] = 1'b1;
            else        classWord[`FP_CLASS_POS_NORMAL] = 1'b1;
        end
    end

endmodule

//--- FpPipeReg.sv
//////////////////////////////////////////////////////////////////////
// One pipeline stage with a valid bit. The payload type is a
// parameter, so the same stage holds requests and responses.
// Latency is one cycle, and there is no back-pressure.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module FpPipeReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     inValid,
    input  payload_t in,
    output logic     outValid,
    output payload_t out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // payload only moves with a valid beat
    always_ff @(posedge clk) begin
        if (inValid) begin
            out <= in;
        end
    end

endmodule

//--- FpOpTypes.sv
//////////////////////////////////////////////////////////////////////
// Operation types of the execute unit: which sub-unit runs, the
// commands of the sign and compare sub-units, and the request and
// response words that travel through the pipeline registers.
//////////////////////////////////////////////////////////////////////

package FpOpTypes;

    // 3 bits leave room for conversion, fma, div and sqrt
    typedef enum logic [2:0] {
        FpUnitType_Move       = 3'd0,
        FpUnitType_Classifier = 3'd1,
        FpUnitType_Sign       = 3'd2,
        FpUnitType_Comparator = 3'd3
    } FpUnitType;

    typedef enum logic [1:0] {
        FpSignCommand_Sgnj  = 2'd0,
        FpSignCommand_Sgnjn = 2'd1,
        FpSignCommand_Sgnjx = 2'd2
    } FpSignCommand;

    typedef enum logic [2:0] {
        FpCmpCommand_Eq  = 3'd0,
        FpCmpCommand_Lt  = 3'd1,
        FpCmpCommand_Le  = 3'd2,
        FpCmpCommand_Min = 3'd3,
        FpCmpCommand_Max = 3'd4
    } FpCmpCommand;

    typedef struct packed {
        FpSignCommand sign;
        FpCmpCommand  cmp;
    } FpUnitCommand;

    // 104 bits
    typedef struct packed {
        FpUnitType      unit;
        FpUnitCommand   command;
        FpTypes::word_t intSrc;
        FpTypes::word_t fpSrc1;
        FpTypes::word_t fpSrc2;
    } FpRequest_t;

    // 70 bits
    typedef struct packed {
        FpTypes::word_t   intResult;
        FpTypes::word_t   fpResult;
        logic             writeFlags;
        FpTypes::fflags_t flags;
    } FpResponse_t;

endpackage

//--- FpTypes.sv
//////////////////////////////////////////////////////////////////////
// Number-format types of the F extension: the binary32 layout, the
// accrued exception flags and the integer register word that also
// carries the FCLASS result. Compile before the operation package.
//////////////////////////////////////////////////////////////////////

`include "FpUnit_defines.svh"

package FpTypes;

    // integer register word, also used for raw FP register contents
    typedef logic [31:0] word_t;

    // IEEE 754 binary32, sign in the top bit
    typedef struct packed {
        logic                        sign;
        logic [`FP_EXP_WIDTH-1:0]    exponent;
        logic [`FP_FRAC_WIDTH-1:0]   fraction;
    } fp32_t;

    // accrued flags in fflags order, NV is bit 4
    typedef struct packed {
        // invalid operation
        logic nv;
        // divide by zero
        logic dz;
        // overflow
        logic of;
        // underflow
        logic uf;
        // inexact
        logic nx;
    } fflags_t;

    // the class word is a word_t with exactly one of bits 0..9 set,
    // see the FP_CLASS_* positions in the defines header

endpackage

//--- FpUnit_defines.svh
//////////////////////////////////////////////////////////////////////
// Shared constants of the single-precision execute unit: binary32
// field widths, the canonical quiet NaN and the FCLASS bit positions.
// Include this file wherever one of these constants is needed.
//////////////////////////////////////////////////////////////////////

`ifndef FP_UNIT_DEFINES_SVH
`define FP_UNIT_DEFINES_SVH

// binary32 layout
`define FP_EXP_WIDTH  8
`define FP_FRAC_WIDTH 23

// returned by min/max when both sources are NaN
`define FP_CANONICAL_NAN 32'h7FC00000

// FCLASS.S result bit positions
`define FP_CLASS_NEG_INF       0
`define FP_CLASS_NEG_NORMAL    1
`define FP_CLASS_NEG_SUBNORMAL 2
`define FP_CLASS_NEG_ZERO      3
`define FP_CLASS_POS_ZERO      4
`define FP_CLASS_POS_SUBNORMAL 5
`define FP_CLASS_POS_NORMAL    6
`define FP_CLASS_POS_INF       7
`define FP_CLASS_SIGNALING_NAN 8
`define FP_CLASS_QUIET_NAN     9

`endif
